/* design/smc_access_counter.sv */
/*
  SMC access counter
  stores the transfer size and counts down the external byte accesses,
  flags the last one
*/
`default_nettype none

module smc_access_counter (
  input  wire                       sys_clk25,
  input  wire                       n_sys_reset25,
  input  wire                       valid_access,  // address cycle strobe
  input  wire smc_mac_pkg::xfer_size_e xfer_size,  // only valid with strobe
  input  wire                       access_done,   // end of one access
  input  wire smc_mac_pkg::smc_state_e next_state,
  output smc_mac_pkg::mac_status_t  status
);

  import smc_mac_pkg::*;

  xfer_size_e  r_xfer_size;   // size of transfer in flight
  xfer_size_e  v_xfer_size;   // validated size
  access_cnt_t load_count;    // start value for a new transfer
  access_cnt_t r_num_access;  // accesses still to go
  logic        count_dec;

  //----------------------------------------------------------------------
  // store transfer size
  //----------------------------------------------------------------------
  always_ff @(posedge sys_clk25 or negedge n_sys_reset25)
  begin
    if (!n_sys_reset25)
      r_xfer_size <= xsiz_8;
    else if (valid_access)
      r_xfer_size <= xfer_size;
  end

  // live size during address cycle, stored size after
  assign v_xfer_size = valid_access ? xfer_size : r_xfer_size;

  //----------------------------------------------------------------------
  // accesses needed on an 8-bit bus
  //----------------------------------------------------------------------
  always_comb
  begin
    case (xfer_size)
      xsiz_16: load_count = 2'd1;  // two accesses
      xsiz_32: load_count = 2'd3;  // four accesses
      default: load_count = 2'd0;  // byte, also code 11
    endcase
  end

  // no step when controller heads to store or idle
  assign count_dec = access_done && (next_state != st_store) &&
                     (next_state != st_idle);

  //----------------------------------------------------------------------
  // access counter
  //----------------------------------------------------------------------
  always_ff @(posedge sys_clk25 or negedge n_sys_reset25)
  begin
    if (!n_sys_reset25)
      r_num_access <= 2'd0;
    else if (valid_access)
      r_num_access <= load_count;           // new transfer wins
    else if (count_dec)
      r_num_access <= r_num_access - 2'd1;
  end

  assign status.size       = v_xfer_size;
  assign status.num_access = r_num_access;
  assign status.mac_done   = (r_num_access == 2'd0);  // last access

  // the external controller must not run more accesses than were loaded
  a_no_underflow : assert property (
    @(posedge sys_clk25) disable iff (!n_sys_reset25)
    (count_dec && !valid_access) |-> (r_num_access != 2'd0)
  );

endmodule

`default_nettype wire

/* design/smc_data_lanes.sv */
/*
  SMC data lanes
  aligns read data onto the internal bus with lane copies for narrow
  reads, and picks the write byte for each external access
*/
`default_nettype none

module smc_data_lanes (
  input  wire smc_mac_pkg::mac_status_t status,
  input  wire                        latch_data,  // last byte is live
  input  wire smc_mac_pkg::byte_t    mem_rdata,
  input  wire smc_mac_pkg::word_t    hold_word,
  input  wire smc_mac_pkg::word_t    write_data,  // steady for transfer
  output smc_mac_pkg::word_t         read_data,
  output smc_mac_pkg::byte_t         mem_wdata
);

  import smc_mac_pkg::*;

  //----------------------------------------------------------------------
  // read path
  //----------------------------------------------------------------------
  // with latch_data high the live byte bypasses the holding register,
  // so the full word is on the bus in the same cycle
  always_comb
  begin
    case (status.size)
      xsiz_32:
      begin
        if (latch_data)
          read_data = {hold_word[31:8], mem_rdata};
        else
          read_data = hold_word;
      end
      xsiz_16:
      begin
        if (latch_data)
          read_data = {2{hold_word[15:8], mem_rdata}};  // both halves
        else
          read_data = {2{hold_word[15:0]}};
      end
      default:
      begin
        // byte, code 11 falls here too
        if (latch_data)
          read_data = {bytes_per_word{mem_rdata}};
        else
          read_data = {bytes_per_word{hold_word[7:0]}};
      end
    endcase
  end

  //----------------------------------------------------------------------
  // write path
  //----------------------------------------------------------------------
  // remaining count doubles as byte index, msb goes out first
  always_comb
  begin
    case (status.num_access)
      2'd3:    mem_wdata = write_data[31:24];
      2'd2:    mem_wdata = write_data[23:16];
      2'd1:    mem_wdata = write_data[15:8];
      default: mem_wdata = write_data[7:0];  // last or only byte
    endcase
  end

endmodule

`default_nettype wire

/* design/smc_mac_lite.sv */
/*
  SMC multiple access controller, 8-bit external bus
  counter, read assembler and data lanes
*/
`default_nettype none

module smc_mac_lite (
  input  wire                        sys_clk25,
  input  wire                        n_sys_reset25,
  input  wire                        valid_access,
  input  wire smc_mac_pkg::xfer_size_e xfer_size,
  input  wire                        access_done,
  input  wire smc_mac_pkg::smc_state_e next_state,
  input  wire                        latch_data,
  input  wire smc_mac_pkg::byte_t    mem_rdata,
  input  wire smc_mac_pkg::word_t    write_data,
  output wire smc_mac_pkg::mac_status_t status,
  output wire smc_mac_pkg::word_t    read_data,
  output wire smc_mac_pkg::byte_t    mem_wdata
);

  import smc_mac_pkg::*;

  wire word_t hold_word;  // assembled read bytes

  smc_access_counter u_access_counter (
    .sys_clk25     (sys_clk25),
    .n_sys_reset25 (n_sys_reset25),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .access_done   (access_done),
    .next_state    (next_state),
    .status        (status)
  );

  smc_read_assembler u_read_assembler (
    .sys_clk25     (sys_clk25),
    .n_sys_reset25 (n_sys_reset25),
    .status        (status),
    .latch_data    (latch_data),
    .mem_rdata     (mem_rdata),
    .hold_word     (hold_word)
  );

  smc_data_lanes u_data_lanes (
    .status     (status),
    .latch_data (latch_data),
    .mem_rdata  (mem_rdata),
    .hold_word  (hold_word),
    .write_data (write_data),
    .read_data  (read_data),
    .mem_wdata  (mem_wdata)
  );

  //----------------------------------------------------------------------
  // protocol checks across counter and data path
  //----------------------------------------------------------------------
  // a read byte in the address cycle would land in a stale lane
  a_no_latch_on_addr : assert property (
    @(posedge sys_clk25) disable iff (!n_sys_reset25)
    latch_data |-> !valid_access
  );

  // unused size code reaching the read lanes
  a_read_size_legal : assert property (
    @(posedge sys_clk25) disable iff (!n_sys_reset25)
    latch_data |-> (status.size != 2'b11)
  );

endmodule

`default_nettype wire

/* design/smc_mac_pkg.sv */
/*
  SMC multiple access controller, shared definitions
  size and state codes, bus data types, status bundle
*/
`default_nettype none

package smc_mac_pkg;

  //----------------------------------------------------------------------
  // bus geometry
  //----------------------------------------------------------------------
  localparam int bytes_per_word = 4;  // internal bus lanes
  localparam int byte_w         = 8;  // external bus width

  typedef logic [byte_w-1:0]                byte_t;  // external data
  typedef logic [bytes_per_word*byte_w-1:0] word_t;  // internal data

  //----------------------------------------------------------------------
  // transfer size, as carried on the internal bus
  //----------------------------------------------------------------------
  typedef enum logic [1:0] {
    xsiz_8  = 2'b00,  // byte
    xsiz_16 = 2'b01,  // halfword
    xsiz_32 = 2'b10   // word, 2'b11 not used
  } xfer_size_e;

  //----------------------------------------------------------------------
  // controller next state, one-hot
  //----------------------------------------------------------------------
  typedef enum logic [4:0] {
    st_idle  = 5'b00001,
    st_le    = 5'b00010,  // latch enable
    st_rw    = 5'b00100,  // access in progress
    st_store = 5'b01000,
    st_float = 5'b10000   // bus turnaround
  } smc_state_e;

  // accesses left after the current one, 0..3
  typedef logic [1:0] access_cnt_t;

  // status bundle from the access counter to the data path
  typedef struct packed {
    xfer_size_e  size;        // validated size
    access_cnt_t num_access;  // remaining count
    logic        mac_done;    // last access of transfer
  } mac_status_t;

endpackage

`default_nettype wire

/* design/smc_read_assembler.sv */
/*
  SMC read assembler
  packs external read bytes into the holding word, first byte most
  significant
*/
`default_nettype none

module smc_read_assembler (
  input  wire                        sys_clk25,
  input  wire                        n_sys_reset25,
  input  wire smc_mac_pkg::mac_status_t status,
  input  wire                        latch_data,  // mem_rdata valid
  input  wire smc_mac_pkg::byte_t    mem_rdata,
  output smc_mac_pkg::word_t         hold_word
);

  import smc_mac_pkg::*;

  word_t next_word;  // holding word after this byte

  //----------------------------------------------------------------------
  // lane select by remaining count
  //----------------------------------------------------------------------
  // count 3 is the first byte of a word, 1 the first of a halfword,
  // 0 the last byte of any transfer
  // lanes below the written one are cleared so a short read starts clean
  always_comb
  begin
    case (status.num_access)
      2'd3:
      begin
        next_word = {mem_rdata, 24'h0};               // top lane
      end
      2'd2:
      begin
        next_word = {hold_word[31:24], mem_rdata, 16'h0};
      end
      2'd1:
      begin
        next_word = {hold_word[31:16], mem_rdata, 8'h0};
      end
      default:
      begin
        next_word = {hold_word[31:8], mem_rdata};     // bottom lane
      end
    endcase
  end

  //----------------------------------------------------------------------
  // holding register
  //----------------------------------------------------------------------
  always_ff @(posedge sys_clk25 or negedge n_sys_reset25)
  begin
    if (!n_sys_reset25)
      hold_word <= '0;
    else if (latch_data)
      hold_word <= next_word;  // one byte per strobe
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the smc_mac_lite testbench with Verilator
# exit status is non-zero when the build, the run or a check fails

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=smc_mac_lite_sim
log_file=sim.log

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found on PATH"
  exit 1
fi

verilator --binary --timing --assert \
  --top-module smc_mac_lite_tb \
  -Mdir "$build_dir" -o "$sim_bin" \
  -f smc_mac_lite.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Test failures found" "$log_file"; then
  echo "simulation reported failures, see $log_file"
  exit 1
fi

echo "simulation finished without failures"
exit 0

/* smc_mac_lite.f */
design/smc_mac_pkg.sv
design/smc_access_counter.sv
design/smc_read_assembler.sv
design/smc_data_lanes.sv
design/smc_mac_lite.sv
test/smc_mac_clkgen.sv
test/smc_mac_lite_tb.sv

/* test/smc_mac_clkgen.sv */
/*
  testbench clock and reset for the SMC access controller
  20 ns clock, reset held low for the first 5 cycles
*/
`default_nettype none

module smc_mac_clkgen (
  output logic sys_clk25,
  output logic n_sys_reset25
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int half_period = 10;  // ns
  localparam int reset_cycles = 5;

  initial
  begin
    sys_clk25     = 1'b0;
    n_sys_reset25 = 1'b0;             // reset from time zero
    repeat (reset_cycles) @(posedge sys_clk25);
    #5 n_sys_reset25 = 1'b1;          // release away from both edges
  end

  always #half_period sys_clk25 = ~sys_clk25;

endmodule

`default_nettype wire

/* test/smc_mac_lite_tb.sv */
/*
  testbench for the SMC multiple access controller
  directed and random byte, halfword and word transfers on the 8-bit bus,
  read assembly, lane copies, write byte order and access counting
*/
`default_nettype none

module smc_mac_lite_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import smc_mac_pkg::*;

  localparam int num_xfers    = 60;  // random transfers after the sweep
  localparam int done_timeout = 8;   // cycles
  localparam int rst_timeout  = 20;  // cycles

  wire         sys_clk25;
  wire         n_sys_reset25;
  logic        valid_access;
  xfer_size_e  xfer_size;
  logic        access_done;
  smc_state_e  next_state;
  logic        latch_data;
  byte_t       mem_rdata;
  word_t       write_data;
  mac_status_t status;
  word_t       read_data;
  byte_t       mem_wdata;

  // expected values set with the stimulus and compared at the falling edge
  logic        word_chk;
  word_t       word_exp;
  logic        byte_chk;
  byte_t       byte_exp;
  logic        status_chk;
  mac_status_t status_exp;

  int checks;
  int word_errors;
  int byte_errors;
  int status_errors;
  bit timed_out;

  smc_mac_clkgen u_clkgen (
    .sys_clk25     (sys_clk25),
    .n_sys_reset25 (n_sys_reset25)
  );

  smc_mac_lite u_smc_mac_lite (
    .sys_clk25     (sys_clk25),
    .n_sys_reset25 (n_sys_reset25),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .access_done   (access_done),
    .next_state    (next_state),
    .latch_data    (latch_data),
    .mem_rdata     (mem_rdata),
    .write_data    (write_data),
    .status        (status),
    .read_data     (read_data),
    .mem_wdata     (mem_wdata)
  );

  //----------------------------------------------------------------------
  // reference model
  //----------------------------------------------------------------------
  function automatic int count_for_size(xfer_size_e size);
    case (size)
      xsiz_32: return 4;
      xsiz_16: return 2;
      default: return 1;  // byte
    endcase
  endfunction

  // bytes in arrival order with the first one on top
  function automatic word_t expected_read(xfer_size_e size, byte_t seq [4]);
    case (size)
      xsiz_32: return {seq[0], seq[1], seq[2], seq[3]};
      xsiz_16: return {seq[0], seq[1], seq[0], seq[1]};  // both halves
      default: return {4{seq[0]}};                       // all lanes
    endcase
  endfunction

  // idx counts accesses from zero and the msb goes out first
  function automatic byte_t expected_write(xfer_size_e size, word_t wword, int idx);
    int lane;
    case (size)
      xsiz_32: lane = 3 - idx;
      xsiz_16: lane = 1 - idx;
      default: lane = 0;
    endcase
    return wword[lane*8 +: 8];
  endfunction

  function automatic xfer_size_e pick_size();
    logic [1:0] code;
    code = 2'($urandom_range(2, 0));  // never the unused code
    return xfer_size_e'(code);
  endfunction

  //----------------------------------------------------------------------
  // compare tasks and checker
  //----------------------------------------------------------------------
  task automatic check_word(string name, word_t got, word_t exp);
    checks++;
    if (got !== exp)
    begin
      word_errors++;
      $display("[ERROR] %0t ns %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_byte(string name, byte_t got, byte_t exp);
    checks++;
    if (got !== exp)
    begin
      byte_errors++;
      $display("[ERROR] %0t ns %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_status(string name, mac_status_t got, mac_status_t exp);
    checks++;
    if (got !== exp)
    begin
      status_errors++;
      $display("[ERROR] %0t ns %s: got size %b cnt %0d done %b expected size %b cnt %0d done %b",
               $time, name, got.size, got.num_access, got.mac_done,
               exp.size, exp.num_access, exp.mac_done);
    end
  endtask

  // sampled mid-cycle when the inputs have settled
  always @(negedge sys_clk25)
  begin
    if (word_chk)
      check_word("read_data", read_data, word_exp);
    if (byte_chk)
      check_byte("mem_wdata", mem_wdata, byte_exp);
    if (status_chk)
      check_status("status", status, status_exp);
  end

  //----------------------------------------------------------------------
  // stimulus helpers
  //----------------------------------------------------------------------
  // advance to the next drive point with strobes low and no expectations
  task automatic step();
    @(posedge sys_clk25);
    #2;
    valid_access = 1'b0;
    xfer_size    = xfer_size_e'(2'($urandom));  // only meaningful with the strobe
    access_done  = 1'b0;
    latch_data   = 1'b0;
    next_state   = st_idle;
    mem_rdata    = 8'($urandom);  // junk on the bus between latches
    word_chk     = 1'b0;
    byte_chk     = 1'b0;
    status_chk   = 1'b0;
  endtask

  task automatic expect_status(xfer_size_e size, int left);
    status_chk            = 1'b1;
    status_exp.size       = size;
    status_exp.num_access = left[1:0];
    status_exp.mac_done   = (left == 0);
  endtask

  task automatic expect_word(word_t w);
    word_chk = 1'b1;
    word_exp = w;
  endtask

  task automatic expect_byte(byte_t b);
    byte_chk = 1'b1;
    byte_exp = b;
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    @(negedge sys_clk25);
    while (!n_sys_reset25 && n < rst_timeout)
    begin
      @(negedge sys_clk25);
      n++;
    end
    if (!n_sys_reset25)
    begin
      $display("timeout: reset still asserted after %0d cycles", rst_timeout);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_mac_done();
    int n;
    n = 0;
    @(negedge sys_clk25);
    while (!status.mac_done && n < done_timeout)
    begin
      @(negedge sys_clk25);
      n++;
    end
    if (!status.mac_done)
    begin
      $display("timeout: mac_done did not rise within %0d cycles at %0t ns",
               done_timeout, $time);
      timed_out = 1'b1;
    end
  endtask

  // occasional done toward store or idle that must leave the count alone
  task automatic maybe_hold(xfer_size_e size, int left);
    if ($urandom_range(3, 0) == 0)
    begin
      access_done = 1'b1;
      next_state  = $urandom_range(1, 0) ? st_store : st_idle;
      expect_status(size, left);
      step();
    end
  endtask

  //----------------------------------------------------------------------
  // transfers
  //----------------------------------------------------------------------
  task automatic run_read(xfer_size_e size);
    byte_t seq [4];
    int    cnt;
    cnt = count_for_size(size);
    for (int i = 0; i < 4; i++)
      seq[i] = 8'($urandom);
    valid_access = 1'b1;                   // address cycle
    xfer_size    = size;
    expect_status(size, 0);                // live size with the old count
    step();
    for (int k = 0; k < cnt; k++)
    begin
      latch_data = 1'b1;
      mem_rdata  = seq[k];
      expect_status(size, cnt - 1 - k);
      if (k == cnt - 1)
        expect_word(expected_read(size, seq));  // live byte bypass
      step();
      access_done = 1'b1;
      next_state  = (k == cnt - 1) ? st_idle : st_rw;
      expect_status(size, cnt - 1 - k);
      if (k == cnt - 1)
        expect_word(expected_read(size, seq));  // from hold word
      step();
      if (k != cnt - 1)
        maybe_hold(size, cnt - 2 - k);
    end
  endtask

  task automatic run_write(xfer_size_e size);
    word_t wword;
    int    cnt;
    int    gap;
    cnt   = count_for_size(size);
    wword = $urandom;
    valid_access = 1'b1;
    xfer_size    = size;
    write_data   = wword;                  // steady for the transfer
    step();
    for (int k = 0; k < cnt; k++)
    begin
      gap = $urandom_range(2, 0);          // stretched access
      for (int g = 0; g < gap; g++)
      begin
        expect_byte(expected_write(size, wword, k));
        expect_status(size, cnt - 1 - k);
        step();
      end
      access_done = 1'b1;
      next_state  = (k == cnt - 1) ? st_idle : st_rw;
      expect_byte(expected_write(size, wword, k));
      expect_status(size, cnt - 1 - k);
      step();
      if (k != cnt - 1)
        maybe_hold(size, cnt - 2 - k);
    end
  endtask

  //----------------------------------------------------------------------
  // main sequence
  //----------------------------------------------------------------------
  initial
  begin
    void'($urandom(15));
    valid_access  = 1'b0;
    xfer_size     = xsiz_8;
    access_done   = 1'b0;
    next_state    = st_idle;
    latch_data    = 1'b0;
    mem_rdata     = '0;
    write_data    = '0;
    word_chk      = 1'b0;
    byte_chk      = 1'b0;
    status_chk    = 1'b0;
    word_exp      = '0;
    byte_exp      = '0;
    status_exp    = '0;
    checks        = 0;
    word_errors   = 0;
    byte_errors   = 0;
    status_errors = 0;
    timed_out     = 1'b0;

    wait_reset_release();
    if (!timed_out)
    begin
      step();
      expect_status(xsiz_8, 0);            // reset values
      step();
    end

    // every size in both directions once
    if (!timed_out)
    begin
      run_read(xsiz_8);
      run_read(xsiz_16);
      run_read(xsiz_32);
      run_write(xsiz_8);
      run_write(xsiz_16);
      run_write(xsiz_32);
      wait_mac_done();
    end

    for (int t = 0; t < num_xfers && !timed_out; t++)
    begin
      step();
      if ($urandom_range(1, 0))
        run_read(pick_size());
      else
        run_write(pick_size());
      wait_mac_done();
    end

    step();
    $display("checks %0d, errors: read_data %0d, mem_wdata %0d, status %0d, timeout %0d",
             checks, word_errors, byte_errors, status_errors, timed_out);
    if (timed_out || (word_errors + byte_errors + status_errors) != 0)
      $display("Test failures found");
    else
      $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire
